// ==== build.f ====
design/fb_pkg.sv
design/raster_timing.sv
design/capture_packer.sv
design/frame_store.sv
design/display_fetch.sv
design/video_fb_top.sv
dv/fb_asserts.sv
dv/tb_video_fb.sv

// ==== design/capture_packer.sv ====
module capture_packer #(
   parameter int ADDR_W   = fb_pkg::ADDR_W,
   parameter int WQ_DEPTH = fb_pkg::WQ_DEPTH
) (
   input  logic            clk,
   input  logic            arst_n,
   input  fb_pkg::pixel_t  pix_in,
   input  logic            pix_valid,
   input  logic            pix_sof,
   input  logic            credit_ret,
   output logic            pix_ready,
   output fb_pkg::wr_req_t wr_req,
   output logic            wr_push
);
   import fb_pkg::*;

   localparam int CNT_W  = $clog2(PIX_PER_WORD);
   localparam int CRED_W = $clog2(WQ_DEPTH + 1);

   word_t             word_q;
   logic [CNT_W-1:0]  cnt_q;
   logic              full_q;
   logic [ADDR_W-1:0] addr_q;
   logic [CRED_W-1:0] credits_q;
   logic              accept;

   // stall only when a finished word has nowhere to go
   assign pix_ready = !(full_q && (credits_q == '0));
   assign accept    = pix_valid && pix_ready;
   assign wr_push   = full_q && (credits_q != '0);

   assign wr_req.addr = addr_q;
   assign wr_req.data = word_q;

   //////////////////////////////
   // pixel packing
   //////////////////////////////

   // new pixels enter at the top, so after four shifts
   // the first one sits in the low byte
   always_ff @(posedge clk) begin
      if (accept) begin
         word_q <= {pix_in, word_q[$bits(word_t)-1:$bits(pixel_t)]};
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q  <= '0;
         full_q <= 1'b0;
         addr_q <= '0;
      end else begin
         if (accept) begin
            if (pix_sof) begin
               // sof drops any partial word and opens word 0
               cnt_q <= CNT_W'(1);
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end

         // a word waiting for credit blocks input, so a push
         // and a word completion never meet in one cycle
         if (accept && !pix_sof && (cnt_q == CNT_W'(PIX_PER_WORD - 1))) begin
            full_q <= 1'b1;
         end else if (wr_push) begin
            full_q <= 1'b0;
         end

         // raster order, wraps naturally after the last word
         if (accept && pix_sof) begin
            addr_q <= '0;
         end else if (wr_push) begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   //////////////////////////////
   // write credits
   //////////////////////////////

   // credits plus queue occupancy always equal WQ_DEPTH
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credits_q <= CRED_W'(WQ_DEPTH);
      end else begin
         unique case ({wr_push, credit_ret})
            2'b10:   credits_q <= credits_q - 1'b1;
            2'b01:   credits_q <= credits_q + 1'b1;
            default: credits_q <= credits_q;
         endcase
      end
   end

endmodule

// ==== design/display_fetch.sv ====
module display_fetch #(
   parameter int H_ACTIVE = fb_pkg::H_ACTIVE,
   parameter int H_TOTAL  = fb_pkg::H_TOTAL,
   parameter int V_ACTIVE = fb_pkg::V_ACTIVE,
   parameter int V_TOTAL  = fb_pkg::V_TOTAL,
   parameter int ADDR_W   = fb_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              arst_n,
   input  fb_pkg::raster_t   raster,
   input  fb_pkg::word_t     rd_data,
   output logic [ADDR_W-1:0] rd_addr,
   output logic              rd_en,
   output fb_pkg::pixel_t    video_out,
   output logic              hsync_n,
   output logic              vsync_n,
   output logic              blank
);
   import fb_pkg::*;

   // look-ahead equals the frame store read latency
   localparam int RD_LAT         = 2;
   localparam int BYTE_W         = $clog2(PIX_PER_WORD);
   localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;

   hcount_t           h_f;
   vcount_t           v_f;
   logic [BYTE_W-1:0] sel_pipe [RD_LAT];

   //////////////////////////////
   // position forecast
   //////////////////////////////

   // two pixels ahead, wrapping into the next line and frame
   always_comb begin
      if (raster.hcount >= hcount_t'(H_TOTAL - RD_LAT)) begin
         h_f = raster.hcount - hcount_t'(H_TOTAL - RD_LAT);
         if (raster.vcount == vcount_t'(V_TOTAL - 1)) begin
            v_f = '0;
         end else begin
            v_f = raster.vcount + 1'b1;
         end
      end else begin
         h_f = raster.hcount + hcount_t'(RD_LAT);
         v_f = raster.vcount;
      end
   end

   // one read per word, only inside the picture
   assign rd_en   = (h_f < hcount_t'(H_ACTIVE)) && (v_f < vcount_t'(V_ACTIVE)) &&
                    (h_f[BYTE_W-1:0] == '0);
   assign rd_addr = ADDR_W'(v_f * WORDS_PER_LINE + h_f / PIX_PER_WORD);

   //////////////////////////////
   // byte index delay line
   //////////////////////////////

   // byte index of the forecast pixel follows its read through the memory
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < RD_LAT; i++) begin
            sel_pipe[i] <= '0;
         end
      end else begin
         sel_pipe[0] <= h_f[BYTE_W-1:0];
         for (int i = 1; i < RD_LAT; i++) begin
            sel_pipe[i] <= sel_pipe[i-1];
         end
      end
   end

   //////////////////////////////
   // output stage
   //////////////////////////////

   // when the word returns, raster has reached the forecast pixel,
   // so its syncs and blank belong with the selected byte
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         video_out <= '0;
         hsync_n   <= 1'b1;
         vsync_n   <= 1'b1;
         blank     <= 1'b0;
      end else begin
         hsync_n <= raster.hsync_n;
         vsync_n <= raster.vsync_n;
         blank   <= raster.blank;
         // black wherever blank is high
         if (raster.blank) begin
            video_out <= '0;
         end else begin
            video_out <= rd_data[$bits(pixel_t) * sel_pipe[RD_LAT-1] +: $bits(pixel_t)];
         end
      end
   end

endmodule

// ==== design/fb_pkg.sv ====
package fb_pkg;

   //////////////////////////////
   // pixel and memory word types
   //////////////////////////////

   // one grey pixel
   typedef logic [7:0]  pixel_t;
   // four pixels per word, pixel 0 in the low byte is leftmost
   typedef logic [31:0] word_t;

   localparam int PIX_PER_WORD = 4;

   // raster position counters
   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;

   //////////////////////////////
   // default geometry
   //////////////////////////////

   // horizontal, in pixels
   localparam int H_ACTIVE     = 16;
   localparam int H_SYNC_START = 18;
   localparam int H_SYNC_END   = 20;
   localparam int H_TOTAL      = 24;

   // vertical, in lines
   localparam int V_ACTIVE     = 8;
   localparam int V_SYNC_START = 8;
   localparam int V_SYNC_END   = 9;
   localparam int V_TOTAL      = 10;

   // 16 x 8 picture at four pixels per word fills 32 words
   localparam int ADDR_W   = 5;
   // write queue entries, also the packer's starting credits
   localparam int WQ_DEPTH = 4;

   typedef logic [ADDR_W-1:0] addr_t;

   // raster position and its decoded flags, all for the same pixel
   typedef struct packed {
      hcount_t hcount;
      vcount_t vcount;
      logic    hsync_n;
      logic    vsync_n;
      logic    blank;
   } raster_t;

   // one queued memory write
   typedef struct packed {
      addr_t addr;
      word_t data;
   } wr_req_t;

endpackage

// ==== design/frame_store.sv ====
module frame_store #(
   parameter int ADDR_W   = fb_pkg::ADDR_W,
   parameter int WQ_DEPTH = fb_pkg::WQ_DEPTH
) (
   input  logic              clk,
   input  logic              arst_n,
   input  fb_pkg::wr_req_t   wr_req,
   input  logic              wr_push,
   input  logic [ADDR_W-1:0] rd_addr,
   input  logic              rd_en,
   output fb_pkg::word_t     rd_data,
   output logic              credit_ret
);
   import fb_pkg::*;

   localparam int PTR_W = (WQ_DEPTH > 1) ? $clog2(WQ_DEPTH) : 1;
   localparam int CNT_W = $clog2(WQ_DEPTH + 1);

   // write queue
   wr_req_t          queue [WQ_DEPTH];
   logic [PTR_W-1:0] head_q;
   logic [PTR_W-1:0] tail_q;
   logic [CNT_W-1:0] count_q;
   wr_req_t          head;
   logic             pop;

   // memory and read pipeline
   word_t             mem [2**ADDR_W];
   logic [ADDR_W-1:0] rd_addr_q;
   logic              rd_pend_q;

   //////////////////////////////
   // arbitration
   //////////////////////////////

   // display reads own the port, writes take the leftover cycles
   assign pop        = !rd_en && (count_q != '0);
   assign credit_ret = pop;
   assign head       = queue[head_q];

   //////////////////////////////
   // write queue
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_push) begin
         queue[tail_q] <= wr_req;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         if (wr_push) begin
            tail_q <= (tail_q == PTR_W'(WQ_DEPTH - 1)) ? '0 : tail_q + 1'b1;
         end
         if (pop) begin
            head_q <= (head_q == PTR_W'(WQ_DEPTH - 1)) ? '0 : head_q + 1'b1;
         end
         // packer credits keep a push away from a full queue
         unique case ({wr_push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   //////////////////////////////
   // memory array
   //////////////////////////////

   // queue head goes to memory on a free port cycle
   always_ff @(posedge clk) begin
      if (pop) begin
         mem[head.addr] <= head.data;
      end
   end

   // registered address stage
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_addr_q <= rd_addr;
      end
   end

   // registered data stage, two cycles after rd_en
   // data holds between reads so the fetch can unpack all four bytes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend_q <= 1'b0;
         rd_data   <= '0;
      end else begin
         rd_pend_q <= rd_en;
         if (rd_pend_q) begin
            rd_data <= mem[rd_addr_q];
         end
      end
   end

endmodule

// ==== design/raster_timing.sv ====
module raster_timing #(
   parameter int H_ACTIVE     = fb_pkg::H_ACTIVE,
   parameter int H_SYNC_START = fb_pkg::H_SYNC_START,
   parameter int H_SYNC_END   = fb_pkg::H_SYNC_END,
   parameter int H_TOTAL      = fb_pkg::H_TOTAL,
   parameter int V_ACTIVE     = fb_pkg::V_ACTIVE,
   parameter int V_SYNC_START = fb_pkg::V_SYNC_START,
   parameter int V_SYNC_END   = fb_pkg::V_SYNC_END,
   parameter int V_TOTAL      = fb_pkg::V_TOTAL
) (
   input  logic            clk,
   input  logic            arst_n,
   output fb_pkg::raster_t raster
);
   import fb_pkg::*;

   hcount_t h_nxt;
   vcount_t v_nxt;
   logic    end_of_line;

   //////////////////////////////
   // next position
   //////////////////////////////

   assign end_of_line = (raster.hcount == hcount_t'(H_TOTAL - 1));

   always_comb begin
      if (end_of_line) begin
         h_nxt = '0;
         // line counter steps only at end of line
         if (raster.vcount == vcount_t'(V_TOTAL - 1)) begin
            v_nxt = '0;
         end else begin
            v_nxt = raster.vcount + 1'b1;
         end
      end else begin
         h_nxt = raster.hcount + 1'b1;
         v_nxt = raster.vcount;
      end
   end

   //////////////////////////////
   // counters and decoded flags
   //////////////////////////////

   // flags decode the next position so they land with the counters
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // position (0,0) is active and outside both sync pulses
         raster.hcount  <= '0;
         raster.vcount  <= '0;
         raster.hsync_n <= 1'b1;
         raster.vsync_n <= 1'b1;
         raster.blank   <= 1'b0;
      end else begin
         raster.hcount  <= h_nxt;
         raster.vcount  <= v_nxt;
         // active low syncs
         raster.hsync_n <= !((h_nxt >= hcount_t'(H_SYNC_START)) &&
                             (h_nxt <  hcount_t'(H_SYNC_END)));
         raster.vsync_n <= !((v_nxt >= vcount_t'(V_SYNC_START)) &&
                             (v_nxt <  vcount_t'(V_SYNC_END)));
         // blank anywhere outside the picture
         raster.blank   <= (h_nxt >= hcount_t'(H_ACTIVE)) ||
                           (v_nxt >= vcount_t'(V_ACTIVE));
      end
   end

endmodule

// ==== design/video_fb_top.sv ====
module video_fb_top #(
   parameter int H_ACTIVE     = fb_pkg::H_ACTIVE,
   parameter int H_SYNC_START = fb_pkg::H_SYNC_START,
   parameter int H_SYNC_END   = fb_pkg::H_SYNC_END,
   parameter int H_TOTAL      = fb_pkg::H_TOTAL,
   parameter int V_ACTIVE     = fb_pkg::V_ACTIVE,
   parameter int V_SYNC_START = fb_pkg::V_SYNC_START,
   parameter int V_SYNC_END   = fb_pkg::V_SYNC_END,
   parameter int V_TOTAL      = fb_pkg::V_TOTAL,
   parameter int ADDR_W       = fb_pkg::ADDR_W,
   parameter int WQ_DEPTH     = fb_pkg::WQ_DEPTH
) (
   input  logic           clk,
   input  logic           arst_n,
   input  fb_pkg::pixel_t pix_in,
   input  logic           pix_valid,
   input  logic           pix_sof,
   output logic           pix_ready,
   output fb_pkg::pixel_t video_out,
   output logic           hsync_n,
   output logic           vsync_n,
   output logic           blank
);
   import fb_pkg::*;

   // packer to frame store
   wr_req_t wr_req;
   logic    wr_push;
   logic    credit_ret;

   // display fetch to frame store
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_en;
   word_t             rd_data;

   raster_t raster;

   //////////////////////////////
   // capture side
   //////////////////////////////

   capture_packer #(
      .ADDR_W   (ADDR_W),
      .WQ_DEPTH (WQ_DEPTH)
   ) u_packer (
      .clk        (clk),
      .arst_n     (arst_n),
      .pix_in     (pix_in),
      .pix_valid  (pix_valid),
      .pix_sof    (pix_sof),
      .credit_ret (credit_ret),
      .pix_ready  (pix_ready),
      .wr_req     (wr_req),
      .wr_push    (wr_push)
   );

   frame_store #(
      .ADDR_W   (ADDR_W),
      .WQ_DEPTH (WQ_DEPTH)
   ) u_store (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_req     (wr_req),
      .wr_push    (wr_push),
      .rd_addr    (rd_addr),
      .rd_en      (rd_en),
      .rd_data    (rd_data),
      .credit_ret (credit_ret)
   );

   //////////////////////////////
   // display side
   //////////////////////////////

   raster_timing #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) u_raster (
      .clk    (clk),
      .arst_n (arst_n),
      .raster (raster)
   );

   display_fetch #(
      .H_ACTIVE (H_ACTIVE),
      .H_TOTAL  (H_TOTAL),
      .V_ACTIVE (V_ACTIVE),
      .V_TOTAL  (V_TOTAL),
      .ADDR_W   (ADDR_W)
   ) u_fetch (
      .clk       (clk),
      .arst_n    (arst_n),
      .raster    (raster),
      .rd_data   (rd_data),
      .rd_addr   (rd_addr),
      .rd_en     (rd_en),
      .video_out (video_out),
      .hsync_n   (hsync_n),
      .vsync_n   (vsync_n),
      .blank     (blank)
   );

endmodule

// ==== dv/fb_asserts.sv ====
module fb_asserts #(
   parameter int WQ_DEPTH = fb_pkg::WQ_DEPTH,
   parameter int CNT_W    = $clog2(WQ_DEPTH + 1)
) (
   input logic             clk,
   input logic             arst_n,
   input logic             wr_push,
   input logic             credit_ret,
   input logic             rd_en,
   input logic [CNT_W-1:0] count,
   input fb_pkg::word_t    rd_data
);

   // words pushed and not yet returned as credit
   logic [CNT_W-1:0] occ;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         occ <= '0;
      end else begin
         case ({wr_push, credit_ret})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
      end
   end

   //////////////////////////////
   // write queue and credits
   //////////////////////////////

   // full queue means the packer holds no credit
   push_not_full: assert property (
      @(posedge clk) disable iff (!arst_n) wr_push |-> (count != CNT_W'(WQ_DEPTH))
   ) else $error("write queue received a push while full");

   // each credit returned stands for a word that was really pushed
   credit_not_empty: assert property (
      @(posedge clk) disable iff (!arst_n) credit_ret |-> (occ != '0)
   ) else $error("credit returned while the write queue was empty");

   //////////////////////////////
   // read latency
   //////////////////////////////

   // new read data only two cycles after a read request
   rd_data_latency: assert property (
      @(posedge clk) disable iff (!arst_n) !$stable(rd_data) |-> $past(rd_en, 2)
   ) else $error("read data changed without a read two cycles earlier");

endmodule

bind frame_store fb_asserts #(
   .WQ_DEPTH (WQ_DEPTH)
) u_asserts (
   .clk        (clk),
   .arst_n     (arst_n),
   .wr_push    (wr_push),
   .credit_ret (credit_ret),
   .rd_en      (rd_en),
   .count      (count_q),
   .rd_data    (rd_data)
);

// ==== dv/fb_golden.hex ====
// frame A of the 16x8 picture, one 32-bit word per line, words 0 to 31 in raster order
// byte n of word k is pixel 4k+n, byte 0 is the leftmost pixel
// line 0
07050301
0f0d0b09
17151311
1f1d1b19
// line 1
27252321
2f2d2b29
37353331
3f3d3b39
// line 2
47454341
4f4d4b49
57555351
5f5d5b59
// line 3
67656361
6f6d6b69
77757371
7f7d7b79
// line 4
87858381
8f8d8b89
97959391
9f9d9b99
// line 5
a7a5a3a1
afadaba9
b7b5b3b1
bfbdbbb9
// line 6
c7c5c3c1
cfcdcbc9
d7d5d3d1
dfdddbd9
// line 7
e7e5e3e1
efedebe9
f7f5f3f1
fffdfbf9

// ==== dv/tb_video_fb.sv ====
module tb_video_fb;
   import fb_pkg::*;

   localparam int NPIX       = H_ACTIVE * V_ACTIVE;
   localparam int NWORDS     = NPIX / PIX_PER_WORD;
   localparam int FRAME      = H_TOTAL * V_TOTAL;
   // longest test spans a little over three frames
   localparam int TEST_LIMIT = 6 * FRAME + 100;

   logic   clk;
   logic   arst_n;
   pixel_t pix_in;
   logic   pix_valid;
   logic   pix_sof;
   logic   pix_ready;
   pixel_t video_out;
   logic   hsync_n;
   logic   vsync_n;
   logic   blank;

   word_t  golden [NWORDS];
   // pixels sent, also the pixels expected back on screen
   pixel_t src_pix [NPIX];
   pixel_t cur_pix [NPIX];
   pixel_t shown [NPIX];

   int    shown_count = 0;
   int    act_cnt = 0;
   int    frames_seen = 0;
   int    blank_nonzero = 0;
   logic  vs_prev = 1'b1;
   int    cycle_count = 0;
   int    test_start = 0;
   int    errors = 0;
   int    test_err0 = 0;
   int    test_blank0 = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    seed;
   string cur_test = "none";

   video_fb_top UUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix_in    (pix_in),
      .pix_valid (pix_valid),
      .pix_sof   (pix_sof),
      .pix_ready (pix_ready),
      .video_out (video_out),
      .hsync_n   (hsync_n),
      .vsync_n   (vsync_n),
      .blank     (blank)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // per-test watchdog
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count - test_start > TEST_LIMIT) begin
         $display("timeout: test %s ran past %0d cycles", cur_test, TEST_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // display monitor
   //////////////////////////////

   // active pixels between two vsync falls form one complete frame
   always @(negedge clk) begin
      if (arst_n) begin
         if (blank && video_out != 8'h00) begin
            blank_nonzero++;
         end
         if (!blank && act_cnt < NPIX) begin
            cur_pix[act_cnt] = video_out;
         end
         if (!blank) begin
            act_cnt++;
         end
         if (vs_prev && !vsync_n) begin
            // first frame after reset is partial
            if (frames_seen > 0) begin
               shown = cur_pix;
               shown_count = act_cnt;
            end
            frames_seen++;
            act_cnt = 0;
         end
         vs_prev = vsync_n;
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("mismatch in %s, %s: expected %0h, actual %0h",
                  cur_test, what, expected, actual);
      end
   endtask

   task automatic start_test(string name);
      cur_test = name;
      test_start = cycle_count;
      test_err0 = errors;
      test_blank0 = blank_nonzero;
   endtask

   task automatic end_test();
      check("video on blank cycles", 0, 32'(blank_nonzero - test_blank0));
      tests_run++;
      if (errors == test_err0) begin
         $display("test %s: pass", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, errors - test_err0);
      end
   endtask

   // pixel 4k+n is byte n of golden word k
   task automatic load_frame(bit invert);
      for (int p = 0; p < NPIX; p++) begin
         src_pix[p] = pixel_t'(golden[p / PIX_PER_WORD] >> (8 * (p % PIX_PER_WORD)));
         if (invert) begin
            src_pix[p] = ~src_pix[p];
         end
      end
   endtask

   // a pixel moves on an edge where valid and ready are both high
   task automatic send_pixels(int n, bit gaps);
      int i;
      bit xfer;
      i = 0;
      while (i < n) begin
         pix_in    = src_pix[i];
         pix_sof   = (i == 0);
         pix_valid = gaps ? (($random(seed) & 1) != 0) : 1'b1;
         xfer      = pix_valid && pix_ready;
         @(posedge clk);
         #1;
         if (xfer) begin
            i++;
         end
      end
      pix_valid = 1'b0;
      pix_sof   = 1'b0;
   endtask

   task automatic wait_frames(int n);
      int target;
      target = frames_seen + n;
      while (frames_seen < target) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_frame();
      check("pixels per frame", NPIX, 32'(shown_count));
      for (int p = 0; p < NPIX; p++) begin
         check($sformatf("pixel %0d", p), 32'(src_pix[p]), 32'(shown[p]));
      end
   endtask

   // also the first output cycle, active pixel (0,0)
   task automatic check_idle_outputs();
      check("pix_ready", 1, 32'(pix_ready));
      check("hsync_n", 1, 32'(hsync_n));
      check("vsync_n", 1, 32'(vsync_n));
      check("blank", 0, 32'(blank));
      check("video_out", 0, 32'(video_out));
   endtask

   // three frames hold at least two full vsync periods
   task automatic measure_geometry();
      int   c;
      int   hfall;
      int   vfall;
      int   hlow;
      int   vlow;
      int   act;
      int   hper;
      int   vper;
      logic hs_q;
      logic vs_q;
      hfall = -1;
      vfall = -1;
      hlow = 0;
      vlow = 0;
      act = 0;
      hper = 0;
      vper = 0;
      @(negedge clk);
      hs_q = hsync_n;
      vs_q = vsync_n;
      for (c = 0; c < 3 * FRAME; c++) begin
         @(negedge clk);
         if (hs_q && !hsync_n) begin
            if (hfall >= 0) begin
               check("hsync period", H_TOTAL, c - hfall);
               hper++;
            end
            hfall = c;
            hlow = 0;
         end
         if (vs_q && !vsync_n) begin
            if (vfall >= 0) begin
               check("vsync period", FRAME, c - vfall);
               check("active cycles per frame", NPIX, act);
               vper++;
            end
            vfall = c;
            vlow = 0;
            act = 0;
         end
         hlow += !hsync_n ? 1 : 0;
         vlow += !vsync_n ? 1 : 0;
         act += !blank ? 1 : 0;
         if (!hs_q && hsync_n && hfall >= 0) begin
            check("hsync low width", H_SYNC_END - H_SYNC_START, hlow);
         end
         if (!vs_q && vsync_n && vfall >= 0) begin
            check("vsync low width", (V_SYNC_END - V_SYNC_START) * H_TOTAL, vlow);
         end
         hs_q = hsync_n;
         vs_q = vsync_n;
      end
      if (hper < 2 * V_TOTAL) begin
         errors++;
         $display("error in %s: fewer than two frames of hsync periods were seen", cur_test);
      end
      if (vper < 2) begin
         errors++;
         $display("error in %s: fewer than two vsync periods were seen", cur_test);
      end
      @(posedge clk);
      #1;
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      arst_n    = 1'b0;
      pix_in    = '0;
      pix_valid = 1'b0;
      pix_sof   = 1'b0;
      seed      = 73632;
      $readmemh("dv/fb_golden.hex", golden);

      start_test("reset_state");
      @(posedge clk);
      #1;
      check_idle_outputs();
      @(posedge clk);
      #1;
      arst_n = 1'b1;
      check_idle_outputs();
      @(posedge clk);
      #1;
      check_idle_outputs();
      end_test();

      start_test("sync_geometry");
      measure_geometry();
      end_test();

      // full rate input, stalls come only from the queue
      start_test("capture_frame_a");
      load_frame(1'b0);
      send_pixels(NPIX, 1'b0);
      wait_frames(2);
      check_frame();
      end_test();

      start_test("overwrite_frame_b");
      load_frame(1'b1);
      send_pixels(NPIX, 1'b1);
      wait_frames(2);
      check_frame();
      end_test();

      // five random words, then frame A restarts at word 0
      start_test("sof_resync");
      for (int p = 0; p < 20; p++) begin
         src_pix[p] = pixel_t'($random(seed));
      end
      send_pixels(20, 1'b0);
      load_frame(1'b0);
      send_pixels(NPIX, 1'b0);
      wait_frames(2);
      check_frame();
      end_test();

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the frame buffer testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing --assert --top-module tb_video_fb -f build.f -o sim_video_fb
if [ $? -ne 0 ]; then
   echo "error: Verilator build failed"
   exit 1
fi

./obj_dir/sim_video_fb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "error: simulation exited with status $status"
   exit 1
fi

# the log decides the result
if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "result: failed"
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "error: no summary found in $LOG"
   exit 1
fi
echo "result: passed"
exit 0
